/* run.sh */
#!/usr/bin/env bash
# Build and run the match controller testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_game -Mdir obj_dir &&
  ./obj_dir/Vtb_game ||
  { echo "Simulation failed"; exit 1; }

/* src.f */
+incdir+test
src/game_pkg.sv
src/display_pkg.sv
src/tick_divider.sv
src/game_timer.sv
src/game_fsm.sv
src/hex_text.sv
src/game_top.sv
test/tb_game.sv

/* src/display_pkg.sv */
package display_pkg;

  // What the six digits are showing
  typedef enum logic [2:0] {
    disp_one_player = 3'd0,
    disp_two_player = 3'd1,
    disp_countdown  = 3'd2,
    disp_fight      = 3'd3,
    disp_p1_win     = 3'd4,
    disp_p2_win     = 3'd5,
    disp_draw       = 3'd6
  } disp_mode_e;

  // Digits first so a number casts straight to its glyph
  typedef enum logic [4:0] {
    g_0, g_1, g_2, g_3, g_4, g_5, g_6, g_7, g_8, g_9,
    g_p, g_f, g_i, g_g, g_h, g_t, g_w, g_n, g_e, g_q,
    g_blank
  } glyph_e;

  typedef struct packed {
    logic [6:0] hex5;
    logic [6:0] hex4;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;
  } hex_bus_t;

  // Bit 0 is segment a and the board drives the segments active low
  function automatic logic [6:0] seg_of(input glyph_e g);
    logic [6:0] lit;
    case (g)
      g_0:     lit = 7'h3f;
      g_1:     lit = 7'h06;
      g_2:     lit = 7'h5b;
      g_3:     lit = 7'h4f;
      g_4:     lit = 7'h66;
      g_5:     lit = 7'h6d;
      g_6:     lit = 7'h7d;
      g_7:     lit = 7'h07;
      g_8:     lit = 7'h7f;
      g_9:     lit = 7'h6f;
      g_p:     lit = 7'h73;
      g_f:     lit = 7'h71;
      g_i:     lit = 7'h30;  // Left-hand stroke
      g_g:     lit = 7'h3d;
      g_h:     lit = 7'h76;
      g_t:     lit = 7'h78;
      g_w:     lit = 7'h2a;  // Best effort on seven segments
      g_n:     lit = 7'h54;
      g_e:     lit = 7'h79;
      g_q:     lit = 7'h67;
      default: lit = 7'h00;  // Blank
    endcase
    return ~lit;
  endfunction

endpackage

/* src/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm
  import game_pkg::*, display_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [3:0]          key,
  input  logic                mode_1p,
  input  logic [HEALTH_W-1:0] p1_health,
  input  logic [HEALTH_W-1:0] p2_health,
  input  logic [DUR_W-1:0]    duration,
  input  logic [DUR_W-1:0]    dwell,
  output game_state_e         state,
  output timer_cmd_e          timer_cmd,
  output logic                state_changed,
  output disp_mode_e          disp_mode
);

  game_state_e next_state;
  logic        key_ok;
  logic        p1_dead;
  logic        p2_dead;

  // Keys are active low; key 0 is not a game key
  assign key_ok  = ~&key[3:1] && (dwell > DUR_W'(KEY_LOCKOUT_SECS));
  assign p1_dead = (p1_health == '0);
  assign p2_dead = (p2_health == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle:      if (key_ok) next_state = st_countdown;
      st_countdown: if (duration == DUR_W'(COUNTDOWN_SECS)) next_state = st_fight;
      st_fight: begin
        if (p1_dead && p2_dead)  next_state = st_draw;
        else if (p1_dead)        next_state = st_p2_win;
        else if (p2_dead)        next_state = st_p1_win;
      end
      st_p1_win, st_p2_win, st_draw: if (key_ok) next_state = st_idle;
      default:      next_state = st_idle;  // Recover from bad encodings
    endcase
  end

  assign state_changed = (next_state != state);

  always_comb begin
    if (state_changed && (next_state inside {st_countdown, st_fight, st_idle})) begin
      timer_cmd = tmr_clear;  // Fresh count on entry
    end else begin
      case (state)
        st_countdown, st_fight:        timer_cmd = tmr_count;
        st_p1_win, st_p2_win, st_draw: timer_cmd = tmr_hold;  // Freeze match length
        default:                       timer_cmd = tmr_clear;
      endcase
    end
  end

  always_comb begin
    case (state)
      st_countdown: disp_mode = disp_countdown;
      st_fight:     disp_mode = disp_fight;
      st_p1_win:    disp_mode = disp_p1_win;
      st_p2_win:    disp_mode = disp_p2_win;
      st_draw:      disp_mode = disp_draw;
      default:      disp_mode = mode_1p ? disp_one_player : disp_two_player;
    endcase
  end

endmodule

/* src/game_pkg.sv */
package game_pkg;

  // Match timing
  localparam int TICKS_PER_SEC    = 60;  // Board clock is 60 Hz
  localparam int TICK_CNT_W       = $clog2(TICKS_PER_SEC);
  localparam int COUNTDOWN_SECS   = 4;
  localparam int KEY_LOCKOUT_SECS = 2;   // Dwell must exceed this

  // Datapath widths
  localparam int DUR_W    = 7;
  localparam int HEALTH_W = 3;

  // Match states
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_countdown = 3'd1,
    st_fight     = 3'd2,
    st_p1_win    = 3'd3,
    st_p2_win    = 3'd4,
    st_draw      = 3'd5
  } game_state_e;

  // Duration counter commands
  typedef enum logic [1:0] {
    tmr_hold  = 2'd0,
    tmr_count = 2'd1,
    tmr_clear = 2'd2
  } timer_cmd_e;

endpackage

/* src/game_timer.sv */
`timescale 1ns/1ps

module game_timer
  import game_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             tick,
  input  timer_cmd_e       cmd,
  input  logic             state_changed,
  output logic [DUR_W-1:0] duration,
  output logic [DUR_W-1:0] dwell
);

  logic dwell_full;

  assign dwell_full = &dwell;

  // Match duration wraps at the top
  always_ff @(posedge clk) begin
    if (reset) begin
      duration <= '0;
    end else begin
      case (cmd)
        tmr_clear: duration <= '0;
        tmr_count: begin
          if (tick) begin
            duration <= duration + 1'b1;
          end
        end
        default: duration <= duration;  // Hold
      endcase
    end
  end

  // Seconds since the last state change saturate so a long
  // stay never falls back into the key lockout
  always_ff @(posedge clk) begin
    if (reset) begin
      dwell <= '0;
    end else if (state_changed) begin
      dwell <= '0;
    end else if (tick && !dwell_full) begin
      dwell <= dwell + 1'b1;
    end
  end

endmodule

/* src/game_top.sv */
`timescale 1ns/1ps

module game_top
  import game_pkg::*, display_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [3:0]          key,
  input  logic [9:0]          sw,
  input  logic [HEALTH_W-1:0] player1_health,
  input  logic [HEALTH_W-1:0] player2_health,
  output game_state_e         game_state,
  output logic [DUR_W-1:0]    game_duration,
  output hex_bus_t            hex
);

  logic             tick;
  logic             state_changed;
  logic [DUR_W-1:0] dwell;
  timer_cmd_e       timer_cmd;
  disp_mode_e       disp_mode;

  tick_divider i_tick_divider (
    .clk   (clk),
    .reset (reset),
    .tick  (tick)
  );

  game_timer i_game_timer (
    .clk           (clk),
    .reset         (reset),
    .tick          (tick),
    .cmd           (timer_cmd),
    .state_changed (state_changed),
    .duration      (game_duration),
    .dwell         (dwell)
  );

  game_fsm i_game_fsm (
    .clk           (clk),
    .reset         (reset),
    .key           (key),
    .mode_1p       (sw[0]),  // Only switch 0 is used
    .p1_health     (player1_health),
    .p2_health     (player2_health),
    .duration      (game_duration),
    .dwell         (dwell),
    .state         (game_state),
    .timer_cmd     (timer_cmd),
    .state_changed (state_changed),
    .disp_mode     (disp_mode)
  );

  hex_text i_hex_text (
    .mode     (disp_mode),
    .duration (game_duration),
    .hex      (hex)
  );

endmodule

/* src/hex_text.sv */
`timescale 1ns/1ps

module hex_text
  import game_pkg::*, display_pkg::*;
(
  input  disp_mode_e       mode,
  input  logic [DUR_W-1:0] duration,
  output hex_bus_t         hex
);

  logic [DUR_W-1:0] tens;
  logic [DUR_W-1:0] ones;
  glyph_e           glyph [6];  // Index 5 is the leftmost digit

  assign tens = (duration / DUR_W'(10)) % DUR_W'(10);
  assign ones = duration % DUR_W'(10);

  always_comb begin
    for (int i = 0; i < 6; i++) begin
      glyph[i] = g_blank;
    end
    case (mode)
      disp_one_player: begin
        glyph[5] = g_1;
        glyph[4] = g_p;
      end
      disp_two_player: begin
        glyph[5] = g_2;
        glyph[4] = g_p;
      end
      disp_countdown: begin
        glyph[1] = glyph_e'(5'(tens));  // Two decimal digits on the right side
        glyph[0] = glyph_e'(5'(ones));
      end
      disp_fight: begin
        glyph[5] = g_f;
        glyph[4] = g_i;
        glyph[3] = g_g;
        glyph[2] = g_h;
        glyph[1] = g_t;
      end
      disp_p1_win, disp_p2_win: begin
        glyph[5] = g_p;
        glyph[4] = (mode == disp_p1_win) ? g_1 : g_2;
        glyph[2] = g_w;
        glyph[1] = g_i;
        glyph[0] = g_n;
      end
      disp_draw: begin
        glyph[5] = g_e;
        glyph[4] = g_q;
      end
      default: ;
    endcase
  end

  assign hex.hex5 = seg_of(glyph[5]);
  assign hex.hex4 = seg_of(glyph[4]);
  assign hex.hex3 = seg_of(glyph[3]);
  assign hex.hex2 = seg_of(glyph[2]);
  assign hex.hex1 = seg_of(glyph[1]);
  assign hex.hex0 = seg_of(glyph[0]);

endmodule

/* src/tick_divider.sv */
`timescale 1ns/1ps

module tick_divider
  import game_pkg::*;
(
  input  logic clk,
  input  logic reset,
  output logic tick
);

  logic [TICK_CNT_W-1:0] count;
  logic                  wrap;

  assign wrap = (count == TICK_CNT_W'(TICKS_PER_SEC - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else begin
      count <= wrap ? '0 : count + 1'b1;
      tick  <= wrap;  // One-cycle enable once per second
    end
  end

endmodule

/* test/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Model registers for the divider, timer and FSM stepped once per rising edge
game_state_e      m_state;
logic [DUR_W-1:0] m_duration;
logic [DUR_W-1:0] m_dwell;
int               m_div_count;
logic             m_tick;

task automatic model_step(input logic rst, input logic [3:0] k,
                          input logic [HEALTH_W-1:0] h1, input logic [HEALTH_W-1:0] h2);
  game_state_e nxt;
  logic        press;
  if (rst) begin
    m_state     = st_idle;
    m_duration  = '0;
    m_dwell     = '0;
    m_div_count = 0;
    m_tick      = 1'b0;
  end else begin
    press = (k[3:1] != 3'b111) && (m_dwell > DUR_W'(KEY_LOCKOUT_SECS));
    nxt   = m_state;
    case (m_state)
      st_idle:      if (press) nxt = st_countdown;
      st_countdown: if (m_duration == DUR_W'(COUNTDOWN_SECS)) nxt = st_fight;
      st_fight: begin
        if (h1 == '0 && h2 == '0) nxt = st_draw;
        else if (h1 == '0)        nxt = st_p2_win;
        else if (h2 == '0)        nxt = st_p1_win;
      end
      st_p1_win, st_p2_win, st_draw: if (press) nxt = st_idle;
      default: nxt = st_idle;
    endcase
    if (nxt != m_state && (nxt == st_countdown || nxt == st_fight || nxt == st_idle))
      m_duration = '0;
    else if (m_state == st_countdown || m_state == st_fight)
      m_duration = m_tick ? m_duration + 1'b1 : m_duration;
    else if (m_state == st_idle)
      m_duration = '0;
    // Win and draw keep the duration frozen
    if (nxt != m_state) m_dwell = '0;
    else if (m_tick && m_dwell != '1) m_dwell = m_dwell + 1'b1;
    m_tick      = (m_div_count == TICKS_PER_SEC - 1);
    m_div_count = m_tick ? 0 : m_div_count + 1;
    m_state     = nxt;
  end
endtask

function automatic hex_bus_t model_hex(input game_state_e st, input logic [DUR_W-1:0] dur,
                                       input logic one_player);
  glyph_e   g [6];
  hex_bus_t h;
  int       tens;
  int       ones;
  for (int i = 0; i < 6; i++) g[i] = g_blank;
  tens = (int'(dur) / 10) % 10;
  ones = int'(dur) % 10;
  case (st)
    st_idle: begin
      g[5] = one_player ? g_1 : g_2;
      g[4] = g_p;
    end
    st_countdown: begin
      g[1] = glyph_e'(tens[4:0]);
      g[0] = glyph_e'(ones[4:0]);
    end
    st_fight: begin
      g[5] = g_f;
      g[4] = g_i;
      g[3] = g_g;
      g[2] = g_h;
      g[1] = g_t;
    end
    st_draw: begin
      g[5] = g_e;
      g[4] = g_q;
    end
    default: begin  // Both win texts
      g[5] = g_p;
      g[4] = (st == st_p1_win) ? g_1 : g_2;
      g[2] = g_w;
      g[1] = g_i;
      g[0] = g_n;
    end
  endcase
  for (int i = 0; i < 6; i++) h[7*i +: 7] = seg_of(g[i]);
  return h;
endfunction

`endif

/* test/tb_game.sv */
`timescale 1ns/1ps

module tb_game
  import game_pkg::*, display_pkg::*;
();

  logic                clk;
  logic                reset;
  logic [3:0]          key;
  logic [9:0]          sw;
  logic [HEALTH_W-1:0] player1_health;
  logic [HEALTH_W-1:0] player2_health;
  game_state_e         game_state;
  logic [DUR_W-1:0]    game_duration;
  hex_bus_t            hex;

  logic        reset_req;
  int          kill_mode;  // 1 kills player 1, 2 kills player 2, 3 both
  logic [31:0] lcg_state;

  `include "tb_model.svh"

  game_top i_dut (
    .clk            (clk),
    .reset          (reset),
    .key            (key),
    .sw             (sw),
    .player1_health (player1_health),
    .player2_health (player2_health),
    .game_state     (game_state),
    .game_duration  (game_duration),
    .hex            (hex)
  );

  always #10 clk = ~clk;

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16]) % n;
  endfunction

  task automatic abort_run(input string why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run($sformatf("Mismatch on %s", name));
    end
  endtask

  task automatic drive_inputs();
    reset  = reset_req;
    key[0] = 1'(rand_below(2));  // Not a game key
    key[3:1] = (rand_below(32) == 0) ? ~(3'b001 << rand_below(3)) : 3'b111;
    sw[9:1] = 9'(rand_below(512));
    if (rand_below(64) == 0) sw[0] = ~sw[0];
    player1_health = (kill_mode == 1 || kill_mode == 3) ? '0 : HEALTH_W'(1 + rand_below(7));
    player2_health = (kill_mode == 2 || kill_mode == 3) ? '0 : HEALTH_W'(1 + rand_below(7));
  endtask

  task automatic compare_outputs();
    hex_bus_t exp_hex;
    exp_hex = model_hex(m_state, m_duration, sw[0]);
    check_value("game_state", 32'(game_state), 32'(m_state));
    check_value("game_duration", 32'(game_duration), 32'(m_duration));
    for (int i = 0; i < 6; i++)
      check_value($sformatf("hex%0d", i), 32'(hex[7*i +: 7]), 32'(exp_hex[7*i +: 7]));
  endtask

  // Inputs change on the falling edge and outputs are read 2 ns after the rising edge
  task automatic run_cycle();
    @(negedge clk);
    drive_inputs();
    @(posedge clk);
    model_step(reset, key, player1_health, player2_health);
    #2;
    compare_outputs();
  endtask

  task automatic wait_for_state(input game_state_e target, input int limit, input string what);
    int n;
    n = 0;
    while (game_state != target && n < limit) begin
      run_cycle();
      n++;
    end
    if (game_state != target) abort_run($sformatf("Timed out waiting for %s", what));
  endtask

  task automatic wait_fight_over(input int limit);
    int n;
    n = 0;
    while (game_state == st_fight && n < limit) begin
      run_cycle();
      n++;
    end
    if (game_state == st_fight) abort_run("Fight did not end after a player's health hit zero");
  endtask

  task automatic check_idle_after_reset();
    check_value("game_state", 32'(game_state), 32'(st_idle));
    check_value("game_duration", 32'(game_duration), 32'd0);
    check_value("hex5", 32'(hex.hex5), 32'(seg_of(sw[0] ? g_1 : g_2)));
  endtask

  task automatic play_match(input int outcome);
    game_state_e expected;
    expected = (outcome == 1) ? st_p2_win : (outcome == 2) ? st_p1_win : st_draw;
    kill_mode = 0;
    wait_for_state(st_countdown, 2000, "countdown start");
    check_value("game_duration", 32'(game_duration), 32'd0);
    wait_for_state(st_fight, 600, "fight start");
    check_value("game_duration", 32'(game_duration), 32'd0);
    repeat (20 + rand_below(300)) run_cycle();
    kill_mode = outcome;
    wait_fight_over(20);
    check_value("game_state", 32'(game_state), 32'(expected));
    kill_mode = 0;
    wait_for_state(st_idle, 2000, "return to idle");
    check_value("game_duration", 32'(game_duration), 32'd0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    key = 4'hf;
    sw = '0;
    player1_health = 3'd7;
    player2_health = 3'd7;
    reset_req = 1'b1;
    kill_mode = 0;
    lcg_state = 32'h92fd;
    model_step(1'b1, key, player1_health, player2_health);
    repeat (10) run_cycle();
    reset_req = 1'b0;
    run_cycle();
    check_idle_after_reset();
    for (int m = 0; m < 6; m++) play_match(m % 3 + 1);
    // Pull reset in the middle of a fight
    wait_for_state(st_countdown, 2000, "countdown before mid-match reset");
    wait_for_state(st_fight, 600, "fight before mid-match reset");
    repeat (40 + rand_below(100)) run_cycle();
    reset_req = 1'b1;
    repeat (10) run_cycle();
    reset_req = 1'b0;
    run_cycle();
    check_idle_after_reset();
    play_match(3);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
